/* sources.f */
hdl/quad_ctrl_pkg.sv
hdl/ctrl_ifs.sv
hdl/layer_sequencer.sv
hdl/row_buffer_loader.sv
hdl/pixel_seq_reader.sv
hdl/ce_issue_chain.sv
hdl/quad_bram_ctrl_top.sv
test/tb_quad_bram_ctrl.sv

/* Bender.yml */
package:
  name: quad_bram_ctrl

sources:
  - files:
      - hdl/quad_ctrl_pkg.sv
      - hdl/ctrl_ifs.sv
      - hdl/layer_sequencer.sv
      - hdl/row_buffer_loader.sv
      - hdl/pixel_seq_reader.sv
      - hdl/ce_issue_chain.sv
      - hdl/quad_bram_ctrl_top.sv
  - target: test
    files:
      - test/tb_quad_bram_ctrl.sv

/* test/tb_quad_bram_ctrl.sv */
module tb_quad_bram_ctrl;
    import quad_ctrl_pkg::*;

    localparam int         NUM_JOBS     = 7;
    localparam int         RESET_CYCLES = 10;
    localparam logic [1:0] GRAY_SEQ [4] = '{2'b00, 2'b01, 2'b11, 2'b10};

    typedef struct {
        int cols;
        int rows;
        int seq_len;
        int full;
        int ack_dly;
        int cmp_dly;
        int flush_dly;
        int exp_reads;
        int exp_fetches;
        int exp_passes;
        int exp_windows;
    } job_entry_t;

    logic                   clk;
    logic                   rst;
    row_pos_t               num_cols;
    row_pos_t               num_rows;
    seq_addr_t              seq_len;
    logic [BUF_COUNT_W-1:0] pfb_full_count;
    logic                   job_start;
    logic                   job_fetch_ack;
    logic                   job_fetch_complete;
    logic                   job_complete_ack;
    logic                   pipeline_flushed;
    logic                   job_accept;
    logic                   job_fetch_request;
    logic                   job_fetch_in_progress;
    logic                   job_complete;
    logic                   pfb_rden;
    logic                   next_row;
    row_pos_t               input_row;
    row_pos_t               input_col;
    logic                   pix_seq_bram_rden;
    seq_addr_t              pix_seq_bram_rd_addr;
    logic [1:0]             gray_code;
    ce_vec_t                ce_execute;
    ce_vec_t                next_kernel;

    job_entry_t jobs [NUM_JOBS];
    integer     seed = 32'hf619_ca58;
    int         cur = 0;
    logic       table_ready = 1'b0;

    // Monitor state, updated on the rising edge
    int                          read_cnt = 0;
    int                          row_cnt = 0;
    int                          fetch_cnt = 0;
    int                          accept_cnt = 0;
    int                          passes_started = 0;
    int                          passes_done = 0;
    int                          rd_cycles = 0;
    int                          nk_cnt = 0;
    int                          tb_count = 0;
    int                          tb_col = 0;
    int                          tb_row = 0;
    logic [1:0]                  pass_gray = 2'b00;
    logic                        flushed_seen = 1'b0;
    logic                        job_finished = 1'b0;
    logic                        rden_q;
    logic                        req_q;
    logic                        cpl_q;
    logic                        ack_taken_q;
    logic                        cpl_taken_q;
    logic                        ip_model;
    logic                        row_end_q;
    logic [SEQ_READ_LATENCY-1:0] rden_hist;
    ce_vec_t                     ce_q;
    ce_vec_t                     nk_q;

    quad_bram_ctrl_top dut_i (
        .clk                   (clk),
        .rst                   (rst),
        .num_cols              (num_cols),
        .num_rows              (num_rows),
        .seq_len               (seq_len),
        .pfb_full_count        (pfb_full_count),
        .job_start             (job_start),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .job_complete_ack      (job_complete_ack),
        .pipeline_flushed      (pipeline_flushed),
        .job_accept            (job_accept),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_in_progress (job_fetch_in_progress),
        .job_complete          (job_complete),
        .pfb_rden              (pfb_rden),
        .next_row              (next_row),
        .input_row             (input_row),
        .input_col             (input_col),
        .pix_seq_bram_rden     (pix_seq_bram_rden),
        .pix_seq_bram_rd_addr  (pix_seq_bram_rd_addr),
        .gray_code             (gray_code),
        .ce_execute            (ce_execute),
        .next_kernel           (next_kernel)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic expect_eq(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
        if (actual !== expected) begin
            $display("mismatch %s: actual 0x%0h expected 0x%0h", name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "check on %s failed", name);
        end
    endtask

    task automatic add_job(input int idx, input int cols, input int rows,
                           input int len, input int full);
        jobs[idx].cols      = cols;
        jobs[idx].rows      = rows;
        jobs[idx].seq_len   = len;
        jobs[idx].full      = full;
        jobs[idx].ack_dly   = $unsigned($random(seed)) % 8;
        jobs[idx].cmp_dly   = $unsigned($random(seed)) % 8;
        jobs[idx].flush_dly = $unsigned($random(seed)) % 8;
        // Expected totals from the job rules
        jobs[idx].exp_reads   = rows * cols;
        jobs[idx].exp_fetches = (rows * cols + full - 1) / full;
        jobs[idx].exp_passes  = rows - PRIME_ROWS + 1;
        jobs[idx].exp_windows = len / WINDOW_CYCLES;
    endtask

    task automatic check_reset_state();
        expect_eq("state", dut_i.u_sequencer.state, ST_IDLE);
        expect_eq("job_accept", job_accept, 1'b0);
        expect_eq("job_fetch_request", job_fetch_request, 1'b0);
        expect_eq("job_fetch_in_progress", job_fetch_in_progress, 1'b0);
        expect_eq("job_complete", job_complete, 1'b0);
        expect_eq("pfb_rden", pfb_rden, 1'b0);
        expect_eq("next_row", next_row, 1'b0);
        expect_eq("pix_seq_bram_rden", pix_seq_bram_rden, 1'b0);
        expect_eq("gray_code", gray_code, 2'b00);
        expect_eq("ce_execute", ce_execute, '0);
        expect_eq("next_kernel", next_kernel, '0);
    endtask

    task automatic run_job(input int idx);
        cur            = idx;
        num_cols       = row_pos_t'(jobs[idx].cols);
        num_rows       = row_pos_t'(jobs[idx].rows);
        seq_len        = seq_addr_t'(jobs[idx].seq_len);
        pfb_full_count = BUF_COUNT_W'(jobs[idx].full);
        @(negedge clk);
        job_start = 1'b1;
        @(negedge clk);
        job_start = 1'b0;
        expect_eq("job_accept", job_accept, 1'b1);
        @(negedge clk);
        expect_eq("job_accept", job_accept, 1'b0);
        while (!job_finished) @(negedge clk);
        expect_eq("pfb_rden_count", read_cnt, jobs[idx].exp_reads);
        expect_eq("next_row_count", row_cnt, jobs[idx].rows);
        expect_eq("job_fetch_request_count", fetch_cnt, jobs[idx].exp_fetches);
        expect_eq("pass_start_count", passes_started, jobs[idx].exp_passes);
        expect_eq("pass_done_count", passes_done, jobs[idx].exp_passes);
        expect_eq("job_accept_count", accept_cnt, 1);
        repeat (3) @(negedge clk);
    endtask

    //////////////////////
    // Main sequence

    initial begin : main_seq
        int j;
        rst                = 1'b1;
        num_cols           = '0;
        num_rows           = '0;
        seq_len            = '0;
        pfb_full_count     = '0;
        job_start          = 1'b0;
        job_fetch_ack      = 1'b0;
        job_fetch_complete = 1'b0;
        job_complete_ack   = 1'b0;
        pipeline_flushed   = 1'b0;
        // cols, rows, seq_len, words per fetch
        add_job(0, 8, 4, 13, 16);
        add_job(1, 5, 3, 6, 15);
        add_job(2, 12, 7, 20, 20);
        add_job(3, 3, 9, 5, 7);
        add_job(4, 16, 5, 25, 64);
        add_job(5, 1, 4, 1, 2);
        add_job(6, 4, 6, 12, 8);
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        check_reset_state();
        rst = 1'b0;
        for (j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    //////////////////////
    // Responders

    initial begin : fetch_responder
        forever begin
            @(negedge clk);
            if (job_fetch_request && !job_fetch_ack) begin
                repeat (jobs[cur].ack_dly) @(negedge clk);
                job_fetch_ack = 1'b1;
                @(negedge clk);
                job_fetch_ack = 1'b0;
                repeat (jobs[cur].cmp_dly) @(negedge clk);
                job_fetch_complete = 1'b1;
                @(negedge clk);
                job_fetch_complete = 1'b0;
            end
        end
    end

    initial begin : complete_responder
        forever begin
            @(negedge clk);
            if (job_complete && !job_complete_ack) begin
                repeat (jobs[cur].cmp_dly) @(negedge clk);
                job_complete_ack = 1'b1;
                @(negedge clk);
                job_complete_ack = 1'b0;
            end
        end
    end

    // Pipeline reports flushed some cycles after the last pass
    initial begin : flush_responder
        forever begin
            do @(negedge clk); while (!job_accept);
            while (passes_done < jobs[cur].exp_passes) @(negedge clk);
            repeat (jobs[cur].flush_dly) @(negedge clk);
            pipeline_flushed = 1'b1;
            while (!job_complete) @(negedge clk);
            pipeline_flushed = 1'b0;
        end
    end

    //////////////////////
    // Monitors

    always @(posedge clk) begin
        if (rst) begin
            rden_q      = 1'b0;
            req_q       = 1'b0;
            cpl_q       = 1'b0;
            ack_taken_q = 1'b0;
            cpl_taken_q = 1'b0;
            ip_model    = 1'b0;
            row_end_q   = 1'b0;
            rden_hist   = '0;
            ce_q        = '0;
            nk_q        = '0;
            tb_col      = 0;
            tb_row      = 0;
        end else begin
            if (job_start) begin
                read_cnt       = 0;
                row_cnt        = 0;
                fetch_cnt      = 0;
                accept_cnt     = 0;
                passes_started = 0;
                passes_done    = 0;
                tb_count       = 0;
                flushed_seen   = 1'b0;
                job_finished   = 1'b0;
            end
            if (job_accept) accept_cnt++;

            // Prefetch reads and row position
            expect_eq("input_col", input_col, tb_col);
            expect_eq("input_row", input_row, tb_row);
            expect_eq("next_row", next_row, row_end_q);
            row_end_q = pfb_rden && (tb_col == jobs[cur].cols - 1);
            if (next_row) row_cnt++;
            if (pfb_rden) begin
                if (tb_count == 0) expect_eq("pfb_rden", pfb_rden, 1'b0);
                tb_count--;
                read_cnt++;
                if (tb_col == jobs[cur].cols - 1) begin
                    tb_col = 0;
                    tb_row++;
                end else begin
                    tb_col++;
                end
            end

            // Fetch exchange
            if (ack_taken_q) expect_eq("job_fetch_request", job_fetch_request, 1'b0);
            if (job_fetch_request && !req_q) fetch_cnt++;
            expect_eq("job_fetch_in_progress", job_fetch_in_progress, ip_model);
            if (job_fetch_complete && ip_model) tb_count = jobs[cur].full;
            if (job_fetch_complete) begin
                ip_model = 1'b0;
            end else if (job_fetch_ack && job_fetch_request) begin
                ip_model = 1'b1;
            end
            ack_taken_q = job_fetch_ack && job_fetch_request;

            // Execution pass
            if (pix_seq_bram_rden && !rden_q) begin
                rd_cycles = 0;
                nk_cnt    = 0;
                pass_gray = GRAY_SEQ[passes_started % 4];
                passes_started++;
            end
            if (pix_seq_bram_rden) begin
                expect_eq("pix_seq_bram_rd_addr", pix_seq_bram_rd_addr, rd_cycles);
                expect_eq("gray_code", gray_code, pass_gray);
                rd_cycles++;
            end
            if (!pix_seq_bram_rden && rden_q) begin
                expect_eq("pix_seq_bram_rden_cycles", rd_cycles, jobs[cur].seq_len);
            end
            expect_eq("ce_execute", ce_execute,
                      {ce_q[NUM_CE-2:0], rden_hist[SEQ_READ_LATENCY-1]});
            expect_eq("next_kernel", next_kernel[NUM_CE-1:1], nk_q[NUM_CE-2:0]);
            if (next_kernel[0]) nk_cnt++;
            if (ce_q[NUM_CE-1] && !ce_execute[NUM_CE-1]) begin
                expect_eq("next_kernel_count", nk_cnt, jobs[cur].exp_windows);
                passes_done++;
            end

            // Completion exchange
            if (pipeline_flushed) flushed_seen = 1'b1;
            if (job_complete && !cpl_q) expect_eq("flushed_before_complete", flushed_seen, 1);
            if (cpl_q && !job_complete) expect_eq("job_complete_ack_seen", cpl_taken_q, 1);
            if (cpl_taken_q) begin
                expect_eq("job_complete", job_complete, 1'b0);
                expect_eq("gray_code", gray_code, 2'b00);
                job_finished = 1'b1;
            end
            if (job_complete && job_complete_ack) begin
                tb_col = 0;
                tb_row = 0;
            end
            cpl_taken_q = job_complete && job_complete_ack;

            rden_hist = {rden_hist[SEQ_READ_LATENCY-2:0], pix_seq_bram_rden};
            rden_q    = pix_seq_bram_rden;
            req_q     = job_fetch_request;
            cpl_q     = job_complete;
            ce_q      = ce_execute;
            nk_q      = next_kernel;
        end
    end

    //////////////////////
    // Watchdog

    initial begin : watchdog
        int limit;
        int k;
        wait (table_ready);
        limit = RESET_CYCLES;
        for (k = 0; k < NUM_JOBS; k++) begin
            limit += 4 * (jobs[k].rows * jobs[k].cols + jobs[k].exp_passes
                          * (jobs[k].seq_len + NUM_CE + SEQ_READ_LATENCY + 20));
        end
        repeat (limit) @(posedge clk);
        $display("Run timed out after %0d cycles before the job table finished", limit);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

endmodule

/* hdl/quad_bram_ctrl_top.sv */
module quad_bram_ctrl_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  quad_ctrl_pkg::row_pos_t               num_cols,
    input  quad_ctrl_pkg::row_pos_t               num_rows,
    input  quad_ctrl_pkg::seq_addr_t              seq_len,
    input  logic [quad_ctrl_pkg::BUF_COUNT_W-1:0] pfb_full_count,
    input  logic                                  job_start,
    input  logic                                  job_fetch_ack,
    input  logic                                  job_fetch_complete,
    input  logic                                  job_complete_ack,
    input  logic                                  pipeline_flushed,
    output logic                                  job_accept,
    output logic                                  job_fetch_request,
    output logic                                  job_fetch_in_progress,
    output logic                                  job_complete,
    output logic                                  pfb_rden,
    output logic                                  next_row,
    output quad_ctrl_pkg::row_pos_t               input_row,
    output quad_ctrl_pkg::row_pos_t               input_col,
    output logic                                  pix_seq_bram_rden,
    output quad_ctrl_pkg::seq_addr_t              pix_seq_bram_rd_addr,
    output logic [1:0]                            gray_code,
    output quad_ctrl_pkg::ce_vec_t                ce_execute,
    output quad_ctrl_pkg::ce_vec_t                next_kernel
);

    load_if ld_bus ();
    seq_if  sq_bus ();

    ////////////////////
    // Job control

    layer_sequencer u_sequencer (
        .clk                   (clk),
        .rst                   (rst),
        .num_rows              (num_rows),
        .job_start             (job_start),
        .job_fetch_ack         (job_fetch_ack),
        .job_fetch_complete    (job_fetch_complete),
        .job_complete_ack      (job_complete_ack),
        .pipeline_flushed      (pipeline_flushed),
        .job_accept            (job_accept),
        .job_fetch_request     (job_fetch_request),
        .job_fetch_in_progress (job_fetch_in_progress),
        .job_complete          (job_complete),
        .ld                    (ld_bus.sequencer),
        .sq                    (sq_bus.sequencer)
    );

    // Prefetch buffer reads
    row_buffer_loader u_loader (
        .clk            (clk),
        .rst            (rst),
        .num_cols       (num_cols),
        .pfb_full_count (pfb_full_count),
        .pfb_rden       (pfb_rden),
        .next_row       (next_row),
        .input_row      (input_row),
        .input_col      (input_col),
        .ld             (ld_bus.loader)
    );

    ////////////////////
    // Execution pass

    pixel_seq_reader u_reader (
        .clk                  (clk),
        .rst                  (rst),
        .seq_len              (seq_len),
        .pix_seq_bram_rden    (pix_seq_bram_rden),
        .pix_seq_bram_rd_addr (pix_seq_bram_rd_addr),
        .gray_code            (gray_code),
        .sq                   (sq_bus.reader)
    );

    ce_issue_chain u_chain (
        .clk         (clk),
        .rst         (rst),
        .ce_execute  (ce_execute),
        .next_kernel (next_kernel),
        .sq          (sq_bus.chain)
    );

endmodule

/* hdl/ce_issue_chain.sv */
module ce_issue_chain (
    input  logic                   clk,
    input  logic                   rst,
    output quad_ctrl_pkg::ce_vec_t ce_execute,
    output quad_ctrl_pkg::ce_vec_t next_kernel,
    seq_if.chain                   sq
);
    import quad_ctrl_pkg::*;

    // Read latency stages followed by one stage per lane
    logic [SEQ_READ_LATENCY+NUM_CE-2:0] en_pipe;
    logic [WIN_CNT_W-1:0]               win_cnt;
    logic                               last_lane_q;

    assign ce_execute = en_pipe[SEQ_READ_LATENCY+NUM_CE-2 -: NUM_CE];

    // Falling edge of the last lane ends the pass
    assign sq.pass_done = last_lane_q && !ce_execute[NUM_CE-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            en_pipe     <= '0;
            last_lane_q <= 1'b0;
        end else begin
            en_pipe     <= {en_pipe[SEQ_READ_LATENCY+NUM_CE-3:0], sq.rden};
            last_lane_q <= ce_execute[NUM_CE-1];
        end
    end

    ////////////////////
    // Kernel window

    // Lane 0 is idle between passes, so the count restarts there
    always_ff @(posedge clk) begin
        if (rst) begin
            win_cnt     <= '0;
            next_kernel <= '0;
        end else begin
            next_kernel[0] <= ce_execute[0] && (win_cnt == WIN_CNT_W'(WINDOW_CYCLES - 1));
            next_kernel[NUM_CE-1:1] <= next_kernel[NUM_CE-2:0];
            if (!ce_execute[0]) begin
                win_cnt <= '0;
            end else if (win_cnt == WIN_CNT_W'(WINDOW_CYCLES - 1)) begin
                win_cnt <= '0;
            end else begin
                win_cnt <= win_cnt + 1'b1;
            end
        end
    end

endmodule

/* hdl/pixel_seq_reader.sv */
module pixel_seq_reader (
    input  logic                     clk,
    input  logic                     rst,
    input  quad_ctrl_pkg::seq_addr_t seq_len,
    output logic                     pix_seq_bram_rden,
    output quad_ctrl_pkg::seq_addr_t pix_seq_bram_rd_addr,
    output logic [1:0]               gray_code,
    seq_if.reader                    sq
);
    import quad_ctrl_pkg::*;

    // Words still to read after the current one
    seq_addr_t  remain;
    logic [1:0] slot;

    assign sq.rden   = pix_seq_bram_rden;
    assign gray_code = {slot[1], slot[1] ^ slot[0]};

    ////////////////////
    // Sequence read

    always_ff @(posedge clk) begin
        if (rst) begin
            pix_seq_bram_rden    <= 1'b0;
            pix_seq_bram_rd_addr <= '0;
            remain               <= '0;
        end else if (sq.start_pass) begin
            pix_seq_bram_rden    <= (seq_len != '0);
            pix_seq_bram_rd_addr <= '0;
            remain               <= seq_len - 1'b1;
        end else if (pix_seq_bram_rden) begin
            if (remain == '0) begin
                pix_seq_bram_rden <= 1'b0;
            end else begin
                remain               <= remain - 1'b1;
                pix_seq_bram_rd_addr <= pix_seq_bram_rd_addr + 1'b1;
            end
        end
    end

    ////////////////////
    // Quad-buffer slot

    always_ff @(posedge clk) begin
        if (rst) begin
            slot <= 2'b00;
        end else if (sq.clear_slot) begin
            slot <= 2'b00;
        end else if (sq.advance_slot) begin
            slot <= slot + 2'b01;
        end
    end

endmodule

/* hdl/row_buffer_loader.sv */
module row_buffer_loader (
    input  logic                                    clk,
    input  logic                                    rst,
    input  quad_ctrl_pkg::row_pos_t                 num_cols,
    input  logic [quad_ctrl_pkg::BUF_COUNT_W-1:0]   pfb_full_count,
    output logic                                    pfb_rden,
    output logic                                    next_row,
    output quad_ctrl_pkg::row_pos_t                 input_row,
    output quad_ctrl_pkg::row_pos_t                 input_col,
    load_if.loader                                  ld
);
    import quad_ctrl_pkg::*;

    logic [BUF_COUNT_W-1:0] word_count;
    row_pos_t               last_col;
    logic                   row_req;
    logic                   priming;
    logic                   col_end;

    assign last_col = num_cols - 1'b1;
    assign priming  = (input_row < row_pos_t'(PRIME_ROWS));

    // One word per cycle while there is data and a reason to read
    assign pfb_rden = (word_count != '0) && (row_req || priming);
    assign col_end  = pfb_rden && (input_col == last_col);

    assign ld.buf_empty   = (word_count == '0);
    assign ld.row_done    = next_row;
    assign ld.rows_loaded = input_row;

    ////////////////////
    // Prefetch word count

    always_ff @(posedge clk) begin
        if (rst) begin
            word_count <= '0;
        end else if (ld.job_clear) begin
            // Leftover words belong to the finished job
            word_count <= '0;
        end else if (ld.fetch_done) begin
            word_count <= pfb_full_count;
        end else if (pfb_rden) begin
            word_count <= word_count - 1'b1;
        end
    end

    ////////////////////
    // Row and column position

    always_ff @(posedge clk) begin
        if (rst) begin
            input_row <= '0;
            input_col <= '0;
            row_req   <= 1'b0;
            next_row  <= 1'b0;
        end else begin
            next_row <= col_end;
            if (ld.job_clear) begin
                input_row <= '0;
                input_col <= '0;
                row_req   <= 1'b0;
            end else begin
                if (ld.load_row) begin
                    row_req <= 1'b1;
                end else if (col_end) begin
                    row_req <= 1'b0;
                end
                if (col_end) begin
                    input_col <= '0;
                    input_row <= input_row + 1'b1;
                end else if (pfb_rden) begin
                    input_col <= input_col + 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/layer_sequencer.sv */
module layer_sequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  quad_ctrl_pkg::row_pos_t num_rows,
    input  logic                    job_start,
    input  logic                    job_fetch_ack,
    input  logic                    job_fetch_complete,
    input  logic                    job_complete_ack,
    input  logic                    pipeline_flushed,
    output logic                    job_accept,
    output logic                    job_fetch_request,
    output logic                    job_fetch_in_progress,
    output logic                    job_complete,
    load_if.sequencer               ld,
    seq_if.sequencer                sq
);
    import quad_ctrl_pkg::*;

    seq_state_t state;
    seq_state_t return_state;
    // A row was requested and has not finished yet
    logic       row_pending;
    logic       complete_taken;

    assign complete_taken = job_complete && job_complete_ack;

    // Completion ack resets row position and slot
    assign ld.job_clear  = complete_taken;
    assign sq.clear_slot = complete_taken;

    // Count reload happens on the same edge as the complete
    assign ld.fetch_done = job_fetch_complete && job_fetch_in_progress;

    ////////////////////
    // Fetch in progress

    always_ff @(posedge clk) begin
        if (rst) begin
            job_fetch_in_progress <= 1'b0;
        end else if (job_fetch_complete) begin
            job_fetch_in_progress <= 1'b0;
        end else if (job_fetch_ack && job_fetch_request) begin
            job_fetch_in_progress <= 1'b1;
        end
    end

    ////////////////////
    // Job FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= ST_IDLE;
            return_state      <= ST_PRIME;
            row_pending       <= 1'b0;
            job_accept        <= 1'b0;
            job_fetch_request <= 1'b0;
            job_complete      <= 1'b0;
            ld.load_row       <= 1'b0;
            sq.start_pass     <= 1'b0;
            sq.advance_slot   <= 1'b0;
        end else begin
            // Strobes default low
            job_accept      <= 1'b0;
            ld.load_row     <= 1'b0;
            sq.start_pass   <= 1'b0;
            sq.advance_slot <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        job_accept <= 1'b1;
                        state      <= ST_PRIME;
                    end
                end

                ST_PRIME: begin
                    // Loader runs on its own until the first rows are in
                    if (ld.rows_loaded >= row_pos_t'(PRIME_ROWS)) begin
                        sq.start_pass <= 1'b1;
                        state         <= ST_ACTIVE;
                    end else if (ld.buf_empty) begin
                        return_state <= ST_PRIME;
                        state        <= ST_WAIT_FETCH;
                    end
                end

                ST_WAIT_FETCH: begin
                    if (job_fetch_ack && job_fetch_request) begin
                        job_fetch_request <= 1'b0;
                    end else if (!job_fetch_in_progress) begin
                        job_fetch_request <= 1'b1;
                    end
                    if (ld.fetch_done) begin
                        state <= return_state;
                    end
                end

                ST_ACTIVE: begin
                    if (sq.pass_done) begin
                        if (ld.rows_loaded >= num_rows) begin
                            state <= ST_WAIT_FLUSH;
                        end else begin
                            ld.load_row     <= 1'b1;
                            sq.advance_slot <= 1'b1;
                            row_pending     <= 1'b1;
                        end
                    end else if (row_pending) begin
                        // Row finished wins over an empty buffer
                        if (ld.row_done) begin
                            row_pending   <= 1'b0;
                            sq.start_pass <= 1'b1;
                        end else if (ld.buf_empty) begin
                            return_state <= ST_ACTIVE;
                            state        <= ST_WAIT_FETCH;
                        end
                    end
                end

                ST_WAIT_FLUSH: begin
                    if (pipeline_flushed) begin
                        state <= ST_SEND_COMPLETE;
                    end
                end

                ST_SEND_COMPLETE: begin
                    if (complete_taken) begin
                        job_complete <= 1'b0;
                        state        <= ST_IDLE;
                    end else begin
                        job_complete <= 1'b1;
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* hdl/ctrl_ifs.sv */
// Sequencer to row-buffer loader
interface load_if;
    import quad_ctrl_pkg::*;

    logic     load_row;
    logic     fetch_done;
    // Pulse when the completed job is acknowledged
    logic     job_clear;
    logic     buf_empty;
    logic     row_done;
    row_pos_t rows_loaded;

    modport sequencer (
        output load_row, fetch_done, job_clear,
        input  buf_empty, row_done, rows_loaded
    );

    modport loader (
        input  load_row, fetch_done, job_clear,
        output buf_empty, row_done, rows_loaded
    );
endinterface

// Sequencer to pixel-sequence reader and CE chain
interface seq_if;
    logic start_pass;
    logic advance_slot;
    logic clear_slot;
    logic rden;
    logic pass_done;

    modport sequencer (output start_pass, advance_slot, clear_slot, input pass_done);
    modport reader (input start_pass, advance_slot, clear_slot, output rden);
    modport chain (input rden, output pass_done);
endinterface

/* hdl/quad_ctrl_pkg.sv */
package quad_ctrl_pkg;

    ////////////////////
    // Sizes

    localparam int ROW_ADDR_W  = 10;
    localparam int BUF_COUNT_W = 10;
    localparam int SEQ_ADDR_W  = 12;

    // Compute-engine layout
    localparam int NUM_AWE        = 4;
    localparam int NUM_CE_PER_AWE = 2;
    localparam int NUM_CE         = NUM_AWE * NUM_CE_PER_AWE;

    ////////////////////
    // Timing

    // Pixel-sequence BRAM read latency in cycles
    localparam int SEQ_READ_LATENCY = 3;
    // One 3x3 window takes this many lane cycles
    localparam int WINDOW_CYCLES    = 6;
    localparam int WIN_CNT_W        = $clog2(WINDOW_CYCLES);
    // Rows in the buffer before the first pass
    localparam int PRIME_ROWS       = 3;

    ////////////////////
    // Types

    typedef enum logic [5:0] {
        ST_IDLE          = 6'b000001,
        ST_PRIME         = 6'b000010,
        ST_WAIT_FETCH    = 6'b000100,
        ST_ACTIVE        = 6'b001000,
        ST_WAIT_FLUSH    = 6'b010000,
        ST_SEND_COMPLETE = 6'b100000
    } seq_state_t;

    typedef logic [ROW_ADDR_W-1:0] row_pos_t;
    typedef logic [SEQ_ADDR_W-1:0] seq_addr_t;
    typedef logic [NUM_CE-1:0]     ce_vec_t;

endpackage
